//--- bip_decode_if.sv
`default_nettype none
`include "bip_settings.svh"

// Decode to execute, registered controls and raw operand
interface bip_decode_if;

    logic                       valid;   // Controls meaningful
    bip_pkg::ctrl_t             ctrl;
    logic [`BIP_NB_OPERAND-1:0] operand; // Address or immediate

    modport decode
    (
        output valid,
        output ctrl,
        output operand
    );

    modport execute
    (
        input valid,
        input ctrl,
        input operand
    );

endinterface

`default_nettype wire

//--- bip_execute_stage.sv
`default_nettype none
`include "bip_settings.svh"

module bip_execute_stage
(
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire                        i_start,    // Clears halted
    input  wire [`BIP_NB_OPERAND-1:0]  i_dbg_addr,
    bip_decode_if.execute              i_decode,
    output logic [`BIP_NB_DATA-1:0]    o_acc,
    output logic                       o_halted,
    output logic [`BIP_NB_DATA-1:0]    o_dbg_data
);

    logic [`BIP_NB_DATA-1:0] data_mem [`BIP_DATA_DEPTH];
    logic [`BIP_NB_DATA-1:0] mem_rd;   // Operand-addressed read
    logic [`BIP_NB_DATA-1:0] imm;
    logic [`BIP_NB_DATA-1:0] opnd_b;
    logic [`BIP_NB_DATA-1:0] alu;
    logic [`BIP_NB_DATA-1:0] acc_next;
    logic                    is_sub;

    //////////////////////////////////////////////////////////////////////
    // Operand select and ALU
    //////////////////////////////////////////////////////////////////////
    assign mem_rd = i_decode.ctrl.rd_ram ? data_mem[i_decode.operand] : '0;
    assign imm    = {{(`BIP_NB_DATA-`BIP_NB_OPERAND){1'b0}}, i_decode.operand}; // Zero-ext

    assign opnd_b = (i_decode.ctrl.sel_b == bip_pkg::SEL_B_IMM) ? imm : mem_rd;

    assign is_sub = (i_decode.ctrl.op == bip_pkg::OP_SUB) ||
                    (i_decode.ctrl.op == bip_pkg::OP_SUBI);

    assign alu = is_sub ? (o_acc - opnd_b) : (o_acc + opnd_b); // 16-bit wrap

    always_comb
    begin
        case (i_decode.ctrl.sel_a)
            bip_pkg::SEL_A_IMM: acc_next = imm;
            bip_pkg::SEL_A_ALU: acc_next = alu;
            default:            acc_next = mem_rd; // Load variable
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Commit: accumulator, data memory, halt
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_acc <= '0;
        else if (i_decode.valid && i_decode.ctrl.wr_acc)
            o_acc <= acc_next;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_decode.valid && i_decode.ctrl.wr_ram)
            data_mem[i_decode.operand] <= o_acc; // Store variable
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_start)
            o_halted <= 1'b0;
        else if (i_decode.valid && i_decode.ctrl.op == bip_pkg::OP_HLT)
            o_halted <= 1'b1;                    // Sticky until restart
    end

    assign o_dbg_data = data_mem[i_dbg_addr]; // Debug peek

endmodule

`default_nettype wire

//--- bip_fetch_if.sv
`default_nettype none
`include "bip_settings.svh"

// Fetch to decode, plus the stop request coming back
interface bip_fetch_if;

    logic                     valid; // Instruction word present
    logic [`BIP_NB_INSTR-1:0] instr;
    logic                     stop;  // Decoder saw a halt

    modport fetch
    (
        output valid,
        output instr,
        input  stop
    );

    modport decode
    (
        input  valid,
        input  instr,
        output stop
    );

endinterface

`default_nettype wire

//--- bip_fetch_stage.sv
`default_nettype none
`include "bip_settings.svh"

module bip_fetch_stage
(
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire                        i_start,     // Begin at address 0
    input  wire                        i_prog_we,   // Load strobe, idle only
    input  wire [`BIP_NB_OPERAND-1:0]  i_prog_addr,
    input  wire [`BIP_NB_INSTR-1:0]    i_prog_data,
    bip_fetch_if.fetch                 o_fetch
);

    logic [`BIP_NB_INSTR-1:0]   prog_mem [`BIP_PROG_DEPTH]; // Program store
    logic [`BIP_NB_OPERAND-1:0] pc;
    logic                       running;

    //////////////////////////////////////////////////////////////////////
    // Run control and program counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            running <= 1'b0;
            pc      <= '0;
        end
        else if (i_start)
        begin
            running <= 1'b1;   // Start wins over a stale stop
            pc      <= '0;
        end
        else if (o_fetch.stop)
        begin
            running <= 1'b0;   // Halt decoded downstream
        end
        else if (running)
        begin
            pc <= pc + 1'b1;   // Wraps at the top of memory
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program memory
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_prog_we && !running)
            prog_mem[i_prog_addr] <= i_prog_data; // Loader port
    end

    // Synchronous read, word lands with its valid
    always_ff @(posedge i_clk)
    begin
        if (running)
            o_fetch.instr <= prog_mem[pc];
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_fetch.valid <= 1'b0;
        else
            o_fetch.valid <= running; // One word per running cycle
    end

endmodule

`default_nettype wire

//--- bip_input.txt
# Record: name, word count, program words, expected accumulator,
# pair count, then data memory address and value pairs; counts decimal, the rest hex
ldi_halt
    2  1FFF 0000
    07FF
    0

store_load
    5  1923 080A 1805 100A 0000
    0123
    1  00A 0123

add_sub
    10 1864 2FFF 0830 2030 3030 3FFF 3865 0831 2802 0000
    0001
    2  030 0863  031 FFFF

halt_stops
    7  1855 0820 0821 1866 0000 0820 0821
    0066
    2  020 0055  021 0055

restart
    8  1801 2801 2801 2801 2801 0840 3806 0000
    FFFF
    1  040 0005

//--- bip_instruction_decoder.sv
`default_nettype none
`include "bip_settings.svh"

module bip_instruction_decoder
(
    input  wire          i_clk,
    input  wire          i_reset,
    bip_fetch_if.decode  i_fetch,
    bip_decode_if.decode o_decode
);

    bip_pkg::opcode_e opcode;
    bip_pkg::ctrl_t   ctrl_dec; // Next-state controls
    logic             halted;   // Drops words trailing a halt

    assign opcode = bip_pkg::opcode_e'(i_fetch.instr[`BIP_NB_INSTR-1 -: `BIP_NB_OPCODE]);

    //////////////////////////////////////////////////////////////////////
    // Opcode to control mapping
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        ctrl_dec.wr_pc  = 1'b1;                // Advance by default
        ctrl_dec.sel_a  = bip_pkg::SEL_A_MEM;
        ctrl_dec.sel_b  = bip_pkg::SEL_B_MEM;
        ctrl_dec.wr_acc = 1'b0;
        ctrl_dec.op     = opcode;
        ctrl_dec.wr_ram = 1'b0;
        ctrl_dec.rd_ram = 1'b0;
        case (opcode)
            bip_pkg::OP_STO:
                ctrl_dec.wr_ram = 1'b1;        // ACC to memory
            bip_pkg::OP_LD:
            begin
                ctrl_dec.wr_acc = 1'b1;
                ctrl_dec.rd_ram = 1'b1;        // Memory to ACC
            end
            bip_pkg::OP_LDI:
            begin
                ctrl_dec.sel_a  = bip_pkg::SEL_A_IMM;
                ctrl_dec.wr_acc = 1'b1;
            end
            bip_pkg::OP_ADD, bip_pkg::OP_SUB:
            begin
                ctrl_dec.sel_a  = bip_pkg::SEL_A_ALU;
                ctrl_dec.wr_acc = 1'b1;
                ctrl_dec.rd_ram = 1'b1;        // B from memory
            end
            bip_pkg::OP_ADDI, bip_pkg::OP_SUBI:
            begin
                ctrl_dec.sel_a  = bip_pkg::SEL_A_ALU;
                ctrl_dec.sel_b  = bip_pkg::SEL_B_IMM;
                ctrl_dec.wr_acc = 1'b1;
            end
            default:
            begin
                // Halt, and anything unknown behaves as halt
                ctrl_dec.wr_pc = 1'b0;
                ctrl_dec.op    = bip_pkg::OP_HLT;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Pipeline register and halt tracking
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_decode.valid <= 1'b0;
            halted         <= 1'b0;
        end
        else
        begin
            o_decode.valid <= i_fetch.valid && !halted;
            if (i_fetch.valid && !halted && !ctrl_dec.wr_pc)
                halted <= 1'b1;                // Halt enters the stage
            else if (!i_fetch.valid)
                halted <= 1'b0;                // Fetch drained, ready for start
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_fetch.valid)
        begin
            o_decode.ctrl    <= ctrl_dec;
            o_decode.operand <= i_fetch.instr[`BIP_NB_OPERAND-1:0];
        end
    end

    assign i_fetch.stop = halted; // Fetch clears running next edge

endmodule

`default_nettype wire

//--- bip_pkg.sv
`default_nettype none
`include "bip_settings.svh"

package bip_pkg;

    // Opcodes, upper five bits of the instruction
    typedef enum logic [`BIP_NB_OPCODE-1:0] {
        OP_HLT  = 5'b00000, // Stop the core
        OP_STO  = 5'b00001, // Mem <= ACC
        OP_LD   = 5'b00010, // ACC <= Mem
        OP_LDI  = 5'b00011, // ACC <= imm
        OP_ADD  = 5'b00100,
        OP_ADDI = 5'b00101,
        OP_SUB  = 5'b00110,
        OP_SUBI = 5'b00111  // Own code, not shared with ADDI
    } opcode_e;

    // Accumulator source
    typedef enum logic [1:0] {
        SEL_A_MEM = 2'd0,
        SEL_A_IMM = 2'd1,
        SEL_A_ALU = 2'd2
    } sel_a_e;

    // ALU second operand
    typedef enum logic {
        SEL_B_MEM = 1'b0,
        SEL_B_IMM = 1'b1
    } sel_b_e;

    typedef struct packed {
        logic    wr_pc;  // Low only for halt
        sel_a_e  sel_a;
        sel_b_e  sel_b;
        logic    wr_acc;
        opcode_e op;
        logic    wr_ram;
        logic    rd_ram;
    } ctrl_t;

endpackage

`default_nettype wire

//--- bip_settings.svh
`ifndef BIP_SETTINGS_SVH
`define BIP_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Instruction format
//////////////////////////////////////////////////////////////////////
`define BIP_NB_INSTR   16   // Full instruction word
`define BIP_NB_OPCODE  5    // Upper bits of the word
`define BIP_NB_OPERAND 11   // Address or immediate

//////////////////////////////////////////////////////////////////////
// Datapath and memories
//////////////////////////////////////////////////////////////////////
`define BIP_NB_DATA    16   // Accumulator and data word
`define BIP_PROG_DEPTH 2048 // One word per operand address
`define BIP_DATA_DEPTH 2048

`endif

//--- bip_top.sv
`default_nettype none
`include "bip_settings.svh"

module bip_top
(
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire                        i_start,
    input  wire                        i_prog_we,
    input  wire [`BIP_NB_OPERAND-1:0]  i_prog_addr,
    input  wire [`BIP_NB_INSTR-1:0]    i_prog_data,
    input  wire [`BIP_NB_OPERAND-1:0]  i_dbg_addr,
    output logic [`BIP_NB_DATA-1:0]    o_acc,
    output logic                       o_halted,
    output logic [`BIP_NB_DATA-1:0]    o_dbg_data
);

    bip_fetch_if  fetch_bus ();  // Fetch to decode
    bip_decode_if decode_bus (); // Decode to execute

    bip_fetch_stage i_fetch_stage
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_prog_we   (i_prog_we),
        .i_prog_addr (i_prog_addr),
        .i_prog_data (i_prog_data),
        .o_fetch     (fetch_bus.fetch)
    );

    bip_instruction_decoder i_instruction_decoder
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_fetch  (fetch_bus.decode),
        .o_decode (decode_bus.decode)
    );

    bip_execute_stage i_execute_stage
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_start    (i_start),
        .i_dbg_addr (i_dbg_addr),
        .i_decode   (decode_bus.execute),
        .o_acc      (o_acc),
        .o_halted   (o_halted),
        .o_dbg_data (o_dbg_data)
    );

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
bip_pkg.sv
bip_fetch_if.sv
bip_decode_if.sv
bip_fetch_stage.sv
bip_instruction_decoder.sv
bip_execute_stage.sv
bip_top.sv
tb_bip_clock.sv
tb_bip_assertions.sv
tb_bip.sv

//--- tb_bip.sv
`default_nettype none
`include "bip_settings.svh"

module tb_bip;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRIVE_DELAY  = 1;   // Inputs change after the edge
    localparam int RESET_CYCLES = 8;
    localparam int HALT_MARGIN  = 30;  // Slack per test on top of the words

    logic                       i_clk;
    logic                       i_reset;
    logic                       i_start;
    logic                       i_prog_we;
    logic [`BIP_NB_OPERAND-1:0] i_prog_addr;
    logic [`BIP_NB_INSTR-1:0]   i_prog_data;
    logic [`BIP_NB_OPERAND-1:0] i_dbg_addr;
    logic [`BIP_NB_DATA-1:0]    o_acc;
    logic                       o_halted;
    logic [`BIP_NB_DATA-1:0]    o_dbg_data;

    // Test records, flattened
    string                      test_name  [$];
    int                         word_first [$]; // Index into prog_words
    int                         word_count [$];
    logic [`BIP_NB_INSTR-1:0]   prog_words [$];
    logic [`BIP_NB_DATA-1:0]    exp_acc    [$];
    int                         pair_first [$]; // Index into exp_addr
    int                         pair_count [$];
    logic [`BIP_NB_OPERAND-1:0] exp_addr   [$];
    logic [`BIP_NB_DATA-1:0]    exp_data   [$];

    int cycle_count = 0;
    int cycle_limit = 0;  // Zero until the data file is read
    int test_errors;
    int pass_count  = 0;
    int fail_count  = 0;
    int sva_errors;

    tb_bip_clock i_clock
    (
        .o_clk (i_clk)
    );

    bip_top i_bip_top
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_prog_we   (i_prog_we),
        .i_prog_addr (i_prog_addr),
        .i_prog_data (i_prog_data),
        .i_dbg_addr  (i_dbg_addr),
        .o_acc       (o_acc),
        .o_halted    (o_halted),
        .o_dbg_data  (o_dbg_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Run length guard
    //////////////////////////////////////////////////////////////////////
    always @(posedge i_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("Run stopped after %0d cycles, the cycle limit", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic next_edge();
        @(posedge i_clk);
        #DRIVE_DELAY;                   // Drive point
    endtask

    task automatic read_tests(output bit ok);
        int          fd;
        int          code;
        int          n;
        int          i;
        bit          bad;
        string       token;
        string       rest;
        logic [31:0] value;
        logic [31:0] data;
        bad = 1'b0;
        fd  = $fopen("bip_input.txt", "r");
        if (fd != 0)
        begin
            while ($fscanf(fd, "%s", token) == 1)
            begin
                if (token[0] == "#")
                    code = $fgets(rest, fd);    // Skip comment line
                else
                begin
                    test_name.push_back(token);
                    code = $fscanf(fd, "%d", n);
                    bad  = bad || (code != 1);
                    word_first.push_back(prog_words.size());
                    word_count.push_back(n);
                    for (i = 0; i < n; i++)
                    begin
                        code = $fscanf(fd, "%h", value);
                        bad  = bad || (code != 1);
                        prog_words.push_back(value[`BIP_NB_INSTR-1:0]);
                    end
                    code = $fscanf(fd, "%h", value);
                    bad  = bad || (code != 1);
                    exp_acc.push_back(value[`BIP_NB_DATA-1:0]);
                    code = $fscanf(fd, "%d", n);
                    bad  = bad || (code != 1);
                    pair_first.push_back(exp_addr.size());
                    pair_count.push_back(n);
                    for (i = 0; i < n; i++)
                    begin
                        code = $fscanf(fd, "%h %h", value, data);
                        bad  = bad || (code != 2);
                        exp_addr.push_back(value[`BIP_NB_OPERAND-1:0]);
                        exp_data.push_back(data[`BIP_NB_DATA-1:0]);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && !bad && (test_name.size() > 0);
    endtask

    task automatic apply_reset();
        i_reset = 1'b1;
        repeat (RESET_CYCLES)
            next_edge();
        i_reset = 1'b0;
    endtask

    task automatic load_program(input int t);
        int i;
        for (i = 0; i < word_count[t]; i++)
        begin
            i_prog_we   = 1'b1;
            i_prog_addr = i[`BIP_NB_OPERAND-1:0];     // Program starts at 0
            i_prog_data = prog_words[word_first[t] + i];
            next_edge();
        end
        i_prog_we = 1'b0;
    endtask

    task automatic check_memory(input int t);
        int i;
        int p;
        for (i = 0; i < pair_count[t]; i++)
        begin
            p          = pair_first[t] + i;
            i_dbg_addr = exp_addr[p];
            next_edge();                            // Combinational peek settles
            assert (o_dbg_data === exp_data[p])
            else
            begin
                $display("Mismatch at %0t: o_dbg_data[%h] expected %h, got %h",
                         $time, exp_addr[p], exp_data[p], o_dbg_data);
                test_errors++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int                       i;
        int                       hlt_idx;
        int                       cycles;
        int                       wait_limit;
        logic [`BIP_NB_INSTR-1:0] word;
        logic [`BIP_NB_OPCODE-1:0] op;
        test_errors = 0;
        hlt_idx     = -1;
        for (i = 0; i < word_count[t]; i++)
        begin
            word = prog_words[word_first[t] + i];
            op   = word[`BIP_NB_INSTR-1 -: `BIP_NB_OPCODE];
            if (hlt_idx < 0 && (op == 0 || op > 7))
                hlt_idx = i;                        // Halt or unknown code
        end
        apply_reset();
        load_program(t);
        i_start = 1'b1;
        next_edge();
        i_start    = 1'b0;
        cycles     = 1;
        wait_limit = word_count[t] + HALT_MARGIN;
        while (o_halted !== 1'b1 && cycles < wait_limit)
        begin
            next_edge();
            cycles++;
        end
        assert (o_halted === 1'b1)
        else
        begin
            $display("Test %s did not halt within %0d cycles after start",
                     test_name[t], wait_limit);
            test_errors++;
        end
        if (o_halted === 1'b1)
        begin
            // One commit per cycle, first one four edges after start
            if (hlt_idx >= 0)
            begin
                assert (cycles == hlt_idx + 4)
                else
                begin
                    $display("Mismatch at %0t: o_halted cycle expected %0d, got %0d",
                             $time, hlt_idx + 4, cycles);
                    test_errors++;
                end
            end
            assert (o_acc === exp_acc[t])
            else
            begin
                $display("Mismatch at %0t: o_acc expected %h, got %h",
                         $time, exp_acc[t], o_acc);
                test_errors++;
            end
            check_memory(t);
        end
        if (test_errors == 0)
            pass_count++;
        else
            fail_count++;
        $display("Test %0d %s: %0d error(s)", t, test_name[t], test_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin : main
        bit ok;
        int t;
        i_reset     = 1'b1;
        i_start     = 1'b0;
        i_prog_we   = 1'b0;
        i_prog_addr = '0;
        i_prog_data = '0;
        i_dbg_addr  = '0;
        read_tests(ok);
        if (!ok)
        begin
            $display("Test data in bip_input.txt is missing or malformed");
            $display("Verification failed");
            $finish;
        end
        else
        begin
            for (t = 0; t < test_name.size(); t++)
                cycle_limit += RESET_CYCLES + word_count[t] + HALT_MARGIN;
            for (t = 0; t < test_name.size(); t++)
                run_test(t);
            sva_errors = i_bip_top.i_execute_stage.i_execute_assertions.error_count;
            $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                     pass_count, fail_count, sva_errors);
            if (fail_count == 0 && sva_errors == 0)
                $display("Verification passed");
            else
                $display("Verification failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb_bip_assertions.sv
`default_nettype none

module tb_bip_assertions
(
    input wire i_clk,
    input wire i_reset,
    input wire i_start,
    input wire i_valid,   // Decode to execute strobe
    input wire i_wr_ram,
    input wire i_wr_acc,
    input wire i_halted
);

    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;  // Read by the testbench top at the end

    //////////////////////////////////////////////////////////////////////
    // Execute stage rules
    //////////////////////////////////////////////////////////////////////
    no_commit_when_halted: assert property (@(posedge i_clk) disable iff (i_reset)
        i_halted |-> !(i_valid && (i_wr_ram || i_wr_acc)))
    else
    begin
        $error("Accumulator or data memory written while halted");
        error_count++;
    end

    // Halt is sticky until a restart or a reset
    halted_holds: assert property (@(posedge i_clk)
        $fell(i_halted) |-> ($past(i_start) || $past(i_reset)))
    else
    begin
        $error("Halted flag dropped without start or reset");
        error_count++;
    end

    one_write_per_instr: assert property (@(posedge i_clk) disable iff (i_reset)
        i_valid |-> !(i_wr_ram && i_wr_acc))
    else
    begin
        $error("Store and accumulator write decoded together");
        error_count++;
    end

endmodule

bind bip_execute_stage tb_bip_assertions i_execute_assertions
(
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_start  (i_start),
    .i_valid  (i_decode.valid),
    .i_wr_ram (i_decode.ctrl.wr_ram),
    .i_wr_acc (i_decode.ctrl.wr_acc),
    .i_halted (o_halted)
);

`default_nettype wire

//--- tb_bip_clock.sv
`default_nettype none

module tb_bip_clock
(
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        o_clk = 1'b0;            // First rising edge at 4 ns
    end

    always #4 o_clk = ~o_clk;    // 8 ns period

endmodule

`default_nettype wire
